//--- Bender.yml
package:
  name: fetch_top

sources:
  - src/fetch_pkg.sv
  - src/icache_predecode.sv
  - src/icache.sv
  - src/imem_refill.sv
  - src/apb_imem_port.sv
  - src/imem_arbiter.sv
  - src/imem_bank.sv
  - src/fetch_top.sv
  - target: test
    files:
      - verif/tb_fetch_top.sv

//--- fetch_top.f
src/fetch_pkg.sv
src/icache_predecode.sv
src/icache.sv
src/imem_refill.sv
src/apb_imem_port.sv
src/imem_arbiter.sv
src/imem_bank.sv
src/fetch_top.sv
verif/tb_fetch_top.sv

//--- src/apb_imem_port.sv
/*
  APB slave to the backing memory, word accesses only, pstrb not supported.
  Unaligned addresses and word addresses of 2**pc_width_p or more give
  pslverr on the first access cycle and leave the memory untouched.
*/
`default_nettype none

module apb_imem_port #(
  parameter int pc_width_p = 14
) (
  input  wire logic clk_i,
  input  wire logic reset_i,
  input  wire logic psel_i,
  input  wire logic penable_i,
  input  wire logic pwrite_i,
  input  wire logic [fetch_pkg::apb_addr_width-1:0] paddr_i,
  input  wire logic [fetch_pkg::instr_width-1:0] pwdata_i,
  output logic [fetch_pkg::instr_width-1:0] prdata_o,
  output logic pready_o,
  output logic pslverr_o,
  output logic req_o,
  output fetch_pkg::imem_req_t req_data_o,
  input  wire logic gnt_i,
  input  wire fetch_pkg::imem_rsp_t rsp_i
);

  import fetch_pkg::*;

  logic access;
  logic addr_err;
  logic done_r;

  assign access = psel_i & penable_i;

  // unaligned or beyond the memory
  assign addr_err = (paddr_i[1:0] != 2'b00) || (|paddr_i[apb_addr_width-1:pc_width_p+2]);

  // one request per access, answered on the cycle after the grant
  assign req_o = access & ~addr_err & ~done_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      done_r <= 1'b0;
    end else begin
      done_r <= req_o & gnt_i;
    end
  end

  assign req_data_o.we = pwrite_i;
  assign req_data_o.addr = imem_addr_max'(paddr_i[pc_width_p+1:2]);
  assign req_data_o.wdata = pwdata_i;

  assign pready_o = done_r | (access & addr_err);
  assign pslverr_o = access & addr_err;
  assign prdata_o = rsp_i.rdata;

  assert property (@(posedge clk_i) disable iff (reset_i) penable_i |-> psel_i);

endmodule

`default_nettype wire

//--- src/fetch_pkg.sv
/*
  Shared definitions for the instruction-fetch subsystem.
  Word addresses in memory requests are at most imem_addr_max bits wide,
  so the PC width of the top level must not exceed it.
*/
`default_nettype none

package fetch_pkg;

  // --------------------
  // rv32 widths and opcodes
  localparam int instr_width = 32;
  localparam int apb_addr_width = 32;

  // branch byte offset without its sign bit
  localparam int bimm_width = 12;
  // word offset bits kept per line, sets the precompute adder width
  localparam int lower_width = bimm_width - 2;

  localparam logic [6:0] opcode_branch = 7'b1100011;
  localparam logic [6:0] opcode_jal = 7'b1101111;

  // --------------------
  // backing memory channel
  localparam int imem_addr_max = 16;

  typedef struct packed {
    logic we;
    logic [imem_addr_max-1:0] addr;
    logic [instr_width-1:0] wdata;
  } imem_req_t;

  // read data, valid one cycle after the granted request
  typedef struct packed {
    logic [instr_width-1:0] rdata;
  } imem_rsp_t;

endpackage

`default_nettype wire

//--- src/fetch_top.sv
/*
  Instruction fetch with cache, refill engine, APB loader port and backing memory.
  pc_width_p must exceed 10 and not exceed the request address width (16).
  Load the program over APB before fetching; lines are never invalidated.
*/
`default_nettype none

module fetch_top #(
  parameter int pc_width_p = 14,
  parameter int icache_addr_width_p = 6
) (
  input  wire logic clk_i,
  input  wire logic reset_i,
  // fetch port
  input  wire logic [pc_width_p-1:0] pc_i,
  input  wire logic pc_wen_i,
  output logic [fetch_pkg::instr_width-1:0] instruction_o,
  output logic [pc_width_p-1:0] jump_addr_o,
  output logic [pc_width_p-1:0] pc_r_o,
  output logic hit_o,
  // apb loader port
  input  wire logic psel_i,
  input  wire logic penable_i,
  input  wire logic pwrite_i,
  input  wire logic [fetch_pkg::apb_addr_width-1:0] paddr_i,
  input  wire logic [fetch_pkg::instr_width-1:0] pwdata_i,
  output logic [fetch_pkg::instr_width-1:0] prdata_o,
  output logic pready_o,
  output logic pslverr_o
);

  import fetch_pkg::*;

  logic miss;
  logic fill_en;
  logic [pc_width_p-1:0] fill_addr;
  logic [instr_width-1:0] fill_instr;
  logic refill_req;
  logic refill_gnt;
  logic apb_req;
  logic apb_gnt;
  logic mem_v;
  imem_req_t refill_data;
  imem_req_t apb_data;
  imem_req_t mem_req;
  imem_rsp_t mem_rsp;

  icache #(.pc_width_p(pc_width_p), .icache_addr_width_p(icache_addr_width_p)) cache (
    .clk_i, .reset_i, .pc_i, .pc_wen_i,
    .fill_en_i(fill_en), .fill_addr_i(fill_addr), .fill_instr_i(fill_instr),
    .instruction_o, .jump_addr_o, .pc_r_o, .hit_o, .miss_o(miss)
  );

  imem_refill #(.pc_width_p(pc_width_p)) refill (
    .clk_i, .reset_i, .miss_i(miss), .pc_i(pc_r_o),
    .req_o(refill_req), .req_data_o(refill_data), .gnt_i(refill_gnt), .rsp_i(mem_rsp),
    .fill_en_o(fill_en), .fill_addr_o(fill_addr), .fill_instr_o(fill_instr)
  );

  apb_imem_port #(.pc_width_p(pc_width_p)) apb_port (
    .clk_i, .reset_i, .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
    .prdata_o, .pready_o, .pslverr_o,
    .req_o(apb_req), .req_data_o(apb_data), .gnt_i(apb_gnt), .rsp_i(mem_rsp)
  );

  imem_arbiter arbiter (
    .clk_i, .reset_i,
    .refill_req_i(refill_req), .refill_data_i(refill_data), .refill_gnt_o(refill_gnt),
    .apb_req_i(apb_req), .apb_data_i(apb_data), .apb_gnt_o(apb_gnt),
    .mem_v_o(mem_v), .mem_req_o(mem_req)
  );

  imem_bank #(.pc_width_p(pc_width_p)) bank (
    .clk_i, .v_i(mem_v), .req_i(mem_req), .rsp_o(mem_rsp)
  );

endmodule

`default_nettype wire

//--- src/icache.sv
/*
  Direct-mapped instruction cache, one word per line.
  The PC is a word address of pc_width_p bits, pc_width_p > 10.
  The core must hold pc_wen_i low until hit_o before writing a new PC.
  No invalidation: memory writes after fetch starts are not seen.
*/
`default_nettype none

module icache #(
  parameter int pc_width_p = 14,
  parameter int icache_addr_width_p = 6
) (
  input  wire logic clk_i,
  input  wire logic reset_i,
  input  wire logic [pc_width_p-1:0] pc_i,
  input  wire logic pc_wen_i,
  input  wire logic fill_en_i,
  input  wire logic [pc_width_p-1:0] fill_addr_i,
  input  wire logic [fetch_pkg::instr_width-1:0] fill_instr_i,
  output logic [fetch_pkg::instr_width-1:0] instruction_o,
  output logic [pc_width_p-1:0] jump_addr_o,
  output logic [pc_width_p-1:0] pc_r_o,
  output logic hit_o,
  output logic miss_o
);

  import fetch_pkg::*;

  localparam int tag_width_lp = pc_width_p - icache_addr_width_p;
  localparam int high_width_lp = pc_width_p - lower_width;
  localparam int lines_lp = 2 ** icache_addr_width_p;

  typedef struct packed {
    logic sign;
    logic cout;
    logic [lower_width-1:0] lower;
    logic [tag_width_lp-1:0] tag;
    logic [instr_width-1:0] instr;
  } entry_t;

  entry_t mem [lines_lp];
  entry_t fill_entry;
  entry_t rd_entry_r;
  logic [lines_lp-1:0] valid_q;
  logic rd_valid_r;
  logic [pc_width_p-1:0] pc_r;
  logic lookup_r;
  logic reread_r;
  logic rd_en;
  logic [icache_addr_width_p-1:0] rd_idx;
  logic [icache_addr_width_p-1:0] fill_idx;
  logic tag_match;

  assign fill_idx = fill_addr_i[icache_addr_width_p-1:0];
  assign fill_entry.tag = fill_addr_i[pc_width_p-1:icache_addr_width_p];
  assign fill_entry.instr = fill_instr_i;

  icache_predecode predecode (
    .fill_addr_i   (fill_addr_i[lower_width-1:0]),
    .fill_instr_i  (fill_instr_i),
    .lower_target_o(fill_entry.lower),
    .lower_cout_o  (fill_entry.cout),
    .lower_sign_o  (fill_entry.sign)
  );

  // --------------------
  // array access
  // read the new pc on a write, re-read pc_r right after a fill
  assign rd_en = pc_wen_i | reread_r;
  assign rd_idx = pc_wen_i ? pc_i[icache_addr_width_p-1:0] : pc_r[icache_addr_width_p-1:0];

  always_ff @(posedge clk_i) begin
    if (fill_en_i) begin
      mem[fill_idx] <= fill_entry;
    end
    if (rd_en) begin
      rd_entry_r <= mem[rd_idx];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= '0;
      rd_valid_r <= 1'b0;
      pc_r <= '0;
      lookup_r <= 1'b0;
      reread_r <= 1'b0;
    end else begin
      if (fill_en_i) begin
        valid_q[fill_idx] <= 1'b1;
      end
      if (rd_en) begin
        rd_valid_r <= valid_q[rd_idx];
      end
      if (pc_wen_i) begin
        pc_r <= pc_i;
        lookup_r <= 1'b1;
      end
      reread_r <= fill_en_i;
    end
  end

  assign tag_match = rd_valid_r && (rd_entry_r.tag == pc_r[pc_width_p-1:icache_addr_width_p]);
  assign hit_o = lookup_r & tag_match;
  assign miss_o = lookup_r & ~tag_match;

  // --------------------
  // target reconstruction
  logic [high_width_lp-1:0] pc_high;
  logic [high_width_lp-1:0] high_out;

  assign pc_high = pc_r[pc_width_p-1:lower_width];

  // negative offset without carry borrows, positive with carry increments
  always_comb begin
    case ({rd_entry_r.sign, rd_entry_r.cout})
      2'b01: high_out = pc_high + 1'b1;
      2'b10: high_out = pc_high - 1'b1;
      default: high_out = pc_high;
    endcase
  end

  assign jump_addr_o = {high_out, rd_entry_r.lower};
  assign instruction_o = rd_entry_r.instr;
  assign pc_r_o = pc_r;

  // refill only runs while the core waits for a hit
  assert property (@(posedge clk_i) disable iff (reset_i) !(fill_en_i && pc_wen_i));

endmodule

`default_nettype wire

//--- src/icache_predecode.sv
/*
  Low part of the branch or JAL target, computed when a line is filled.
  JAL offsets beyond +-4 KiB are truncated to the branch range, so the
  reconstructed target is only correct inside that range.
*/
`default_nettype none

module icache_predecode (
  input  wire logic [fetch_pkg::lower_width-1:0] fill_addr_i,
  input  wire logic [fetch_pkg::instr_width-1:0] fill_instr_i,
  output logic [fetch_pkg::lower_width-1:0] lower_target_o,
  output logic lower_cout_o,
  output logic lower_sign_o
);

  import fetch_pkg::*;

  logic [6:0] opcode;
  logic is_branch;
  logic is_jal;
  logic [lower_width-1:0] offset;
  logic sign;
  logic [lower_width:0] sum;

  assign opcode = fill_instr_i[6:0];
  assign is_branch = (opcode == opcode_branch);
  assign is_jal = (opcode == opcode_jal);

  // word offset, i.e. byte immediate bits [11:2], plus its sign
  always_comb begin
    offset = '0;
    sign = 1'b0;
    if (is_branch) begin
      sign = fill_instr_i[31];
      offset = {fill_instr_i[7], fill_instr_i[30:25], fill_instr_i[11:9]};
    end else if (is_jal) begin
      // imm[11] sits at bit 20, imm[10:2] at bits 30:22
      sign = fill_instr_i[31];
      offset = {fill_instr_i[20], fill_instr_i[30:22]};
    end
  end

  // unsigned add, the sign is folded back in at read time
  assign sum = {1'b0, fill_addr_i} + {1'b0, offset};

  always_comb begin
    if (is_branch || is_jal) begin
      lower_target_o = sum[lower_width-1:0];
      lower_cout_o = sum[lower_width];
      lower_sign_o = sign;
    end else begin
      lower_target_o = '0;
      lower_cout_o = 1'b0;
      lower_sign_o = 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- src/imem_arbiter.sv
/*
  Two-way round-robin arbiter for the single memory port.
  Grants are combinational; requesters hold their request until granted.
*/
`default_nettype none

module imem_arbiter (
  input  wire logic clk_i,
  input  wire logic reset_i,
  input  wire logic refill_req_i,
  input  wire fetch_pkg::imem_req_t refill_data_i,
  output logic refill_gnt_o,
  input  wire logic apb_req_i,
  input  wire fetch_pkg::imem_req_t apb_data_i,
  output logic apb_gnt_o,
  output logic mem_v_o,
  output fetch_pkg::imem_req_t mem_req_o
);

  // set when the apb port was served last
  logic last_apb_r;

  // on contention the requester not served last wins
  assign refill_gnt_o = refill_req_i & (~apb_req_i | last_apb_r);
  assign apb_gnt_o = apb_req_i & (~refill_req_i | ~last_apb_r);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      last_apb_r <= 1'b0;
    end else if (apb_gnt_o) begin
      last_apb_r <= 1'b1;
    end else if (refill_gnt_o) begin
      last_apb_r <= 1'b0;
    end
  end

  assign mem_v_o = refill_gnt_o | apb_gnt_o;
  assign mem_req_o = apb_gnt_o ? apb_data_i : refill_data_i;

  // a requester refused once is served on the next cycle
  assert property (@(posedge clk_i) disable iff (reset_i)
    apb_req_i && !apb_gnt_o |=> apb_gnt_o);
  assert property (@(posedge clk_i) disable iff (reset_i)
    refill_req_i && !refill_gnt_o |=> refill_gnt_o);

endmodule

`default_nettype wire

//--- src/imem_bank.sv
/*
  Single-port backing memory of 2**pc_width_p words.
  Read data appears one cycle after a valid read; writes return nothing.
*/
`default_nettype none

module imem_bank #(
  parameter int pc_width_p = 14
) (
  input  wire logic clk_i,
  input  wire logic v_i,
  input  wire fetch_pkg::imem_req_t req_i,
  output fetch_pkg::imem_rsp_t rsp_o
);

  import fetch_pkg::*;

  logic [instr_width-1:0] mem [2 ** pc_width_p];
  logic [pc_width_p-1:0] addr;

  assign addr = req_i.addr[pc_width_p-1:0];

  // read data holds until the next read
  always_ff @(posedge clk_i) begin
    if (v_i) begin
      if (req_i.we) begin
        mem[addr] <= req_i.wdata;
      end else begin
        rsp_o.rdata <= mem[addr];
      end
    end
  end

endmodule

`default_nettype wire

//--- src/imem_refill.sv
/*
  One word is read from the backing memory per miss.
  The cache is written in the cycle the read data returns, and miss_i
  is ignored until the cache has re-read the filled line.
*/
`default_nettype none

module imem_refill #(
  parameter int pc_width_p = 14
) (
  input  wire logic clk_i,
  input  wire logic reset_i,
  input  wire logic miss_i,
  input  wire logic [pc_width_p-1:0] pc_i,
  output logic req_o,
  output fetch_pkg::imem_req_t req_data_o,
  input  wire logic gnt_i,
  input  wire fetch_pkg::imem_rsp_t rsp_i,
  output logic fill_en_o,
  output logic [pc_width_p-1:0] fill_addr_o,
  output logic [fetch_pkg::instr_width-1:0] fill_instr_o
);

  import fetch_pkg::*;

  // s_data covers both waiting for the data and writing it
  typedef enum logic [1:0] {s_idle, s_req, s_data, s_settle} state_e;

  state_e state_r;
  logic [pc_width_p-1:0] miss_pc_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= s_idle;
    end else begin
      case (state_r)
        s_idle: if (miss_i) state_r <= s_req;
        s_req: if (gnt_i) state_r <= s_data;
        s_data: state_r <= s_settle;
        default: state_r <= s_idle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_r == s_idle && miss_i) begin
      miss_pc_r <= pc_i;
    end
  end

  assign req_o = (state_r == s_req);
  assign req_data_o.we = 1'b0;
  assign req_data_o.addr = imem_addr_max'(miss_pc_r);
  assign req_data_o.wdata = '0;

  assign fill_en_o = (state_r == s_data);
  assign fill_addr_o = miss_pc_r;
  assign fill_instr_o = rsp_i.rdata;

  // the re-read after a fill must find the line
  assert property (@(posedge clk_i) disable iff (reset_i)
    state_r == s_settle |=> !miss_i);

endmodule

`default_nettype wire

//--- verif/tb_fetch_top.sv
/*
  Testbench for fetch_top. A program is loaded over APB before any fetch,
  since the cache is never invalidated. Concurrent assertions do all the
  checking, and each wait loop stops the run on its own timeout.
*/
`default_nettype none

module tb_fetch_top;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int pc_width = 14;
  localparam int index_width = 6;
  localparam int tag_width = pc_width - index_width;
  localparam int mem_words = 2 ** pc_width;
  localparam int lines = 2 ** index_width;
  localparam int apb_timeout = 20;
  localparam int fetch_timeout = 40;
  // blocks of 8 words around 10-bit boundaries and the top of the pc range
  localparam int unsigned block_base [5] = '{32'h0, 32'h3fc, 32'h7fc, 32'hbfc, 32'h3ff8};

  logic clk;
  logic reset;
  logic [pc_width-1:0] pc;
  logic pc_wen;
  logic [31:0] instruction;
  logic [pc_width-1:0] jump_addr;
  logic [pc_width-1:0] pc_r;
  logic hit;
  logic psel;
  logic penable;
  logic pwrite;
  logic [31:0] paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic pready;
  logic pslverr;

  // reference copy of memory and of the cache tags
  logic [31:0] mem_model [mem_words];
  int jump_off [mem_words];
  bit is_ctrl [mem_words];
  logic [tag_width-1:0] line_tag [lines];
  bit line_valid [lines];
  int unsigned prog_addrs [$];

  logic [pc_width-1:0] exp_pc;
  logic [31:0] exp_instr;
  logic [pc_width-1:0] exp_jump;
  logic exp_ctrl;
  logic exp_hit;
  logic [31:0] exp_rdata;
  logic exp_err;

  fetch_top #(.pc_width_p(pc_width), .icache_addr_width_p(index_width)) dut (
    .clk_i(clk), .reset_i(reset), .pc_i(pc), .pc_wen_i(pc_wen),
    .instruction_o(instruction), .jump_addr_o(jump_addr), .pc_r_o(pc_r), .hit_o(hit),
    .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite), .paddr_i(paddr),
    .pwdata_i(pwdata), .prdata_o(prdata), .pready_o(pready), .pslverr_o(pslverr)
  );

  always #2 clk = ~clk;

  // --------------------
  // failure reporting
  task automatic stop_run();
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic report_failure(input string what);
    $display("%s at %0t", what, $time);
    stop_run();
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
    $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, expected);
    stop_run();
  endtask

  // --------------------
  // checks
  reset_state: assert property (@(posedge clk) $fell(reset) |-> !hit && !pready && pc_r == '0)
    else report_failure("outputs were not cleared by reset");
  hit_timing: assert property (@(posedge clk) disable iff (reset) pc_wen |=> hit == exp_hit)
    else report_mismatch("hit_o", 32'($sampled(hit)), 32'(exp_hit));
  fetch_pc: assert property (@(posedge clk) disable iff (reset) hit && !pc_wen |-> pc_r == exp_pc)
    else report_mismatch("pc_r_o", 32'($sampled(pc_r)), 32'(exp_pc));
  fetch_instr: assert property (@(posedge clk) disable iff (reset)
    hit && !pc_wen |-> instruction == exp_instr)
    else report_mismatch("instruction_o", $sampled(instruction), exp_instr);
  fetch_target: assert property (@(posedge clk) disable iff (reset)
    hit && !pc_wen && exp_ctrl |-> jump_addr == exp_jump)
    else report_mismatch("jump_addr_o", 32'($sampled(jump_addr)), 32'(exp_jump));
  fetch_hold: assert property (@(posedge clk) disable iff (reset) hit && !pc_wen |=>
    hit && $stable(instruction) && $stable(jump_addr) && $stable(pc_r))
    else report_failure("fetch outputs changed while pc_wen_i was low");
  apb_status: assert property (@(posedge clk) disable iff (reset)
    psel && penable && pready |-> pslverr == exp_err)
    else report_mismatch("pslverr_o", 32'($sampled(pslverr)), 32'(exp_err));
  apb_error_fast: assert property (@(posedge clk) disable iff (reset)
    psel && penable && exp_err |-> pready)
    else report_failure("error response missed the first access cycle");
  apb_rdata: assert property (@(posedge clk) disable iff (reset)
    psel && penable && pready && !pwrite && !exp_err |-> prdata == exp_rdata)
    else report_mismatch("prdata_o", $sampled(prdata), exp_rdata);

  // --------------------
  // stimulus
  // branch or jal with a word offset inside +-1024 words
  function automatic logic [31:0] encode_ctrl(input bit jal, input int word_off);
    logic [20:0] imm;
    logic [9:0] regs;
    imm = 21'(word_off * 4);
    regs = 10'($urandom);
    if (jal) begin
      return {imm[20], imm[10:1], imm[11], imm[19:12], regs[4:0], 7'b1101111};
    end
    return {imm[12], imm[10:5], regs, 3'b000, imm[4:1], imm[11], 7'b1100011};
  endfunction

  task automatic add_word(input int unsigned addr);
    int unsigned kind;
    logic [31:0] rnd;
    kind = $urandom % 3;
    rnd = $urandom;
    jump_off[addr] = int'($urandom % 2048) - 1024;
    is_ctrl[addr] = (kind != 0);
    if (kind == 0) begin
      mem_model[addr] = {rnd[31:7], 7'b0010011};
    end else begin
      mem_model[addr] = encode_ctrl(kind == 2, jump_off[addr]);
    end
    prog_addrs.push_back(addr);
  endtask

  // called and returns 1 ns after a rising edge
  task automatic apb_access(input logic write, input logic [31:0] addr,
                            input logic [31:0] wdata, input logic err_expected);
    int waited;
    exp_err = err_expected;
    exp_rdata = err_expected ? '0 : mem_model[addr[pc_width+1:2]];
    psel = 1'b1;
    penable = 1'b0;
    pwrite = write;
    paddr = addr;
    pwdata = wdata;
    @(posedge clk);
    #1;
    penable = 1'b1;
    waited = 0;
    #2;
    while (!pready) begin
      waited++;
      if (waited > apb_timeout) begin
        report_failure($sformatf("APB access to %h never completed", addr));
      end
      @(posedge clk);
      #3;
    end
    @(posedge clk);
    #1;
    psel = 1'b0;
    penable = 1'b0;
    if (write && !err_expected) begin
      mem_model[addr[pc_width+1:2]] = wdata;
    end
  endtask

  task automatic fetch(input int unsigned addr);
    int waited;
    int unsigned idx;
    logic [tag_width-1:0] tag;
    idx = addr % lines;
    tag = tag_width'(addr / lines);
    exp_pc = pc_width'(addr);
    exp_instr = mem_model[addr];
    exp_ctrl = is_ctrl[addr];
    exp_jump = pc_width'(int'(addr) + jump_off[addr]);
    exp_hit = line_valid[idx] && (line_tag[idx] == tag);
    pc = pc_width'(addr);
    pc_wen = 1'b1;
    @(posedge clk);
    #1;
    pc_wen = 1'b0;
    waited = 0;
    #2;
    while (!hit) begin
      waited++;
      if (waited > fetch_timeout) begin
        report_failure($sformatf("fetch of pc %h never raised hit_o", addr));
      end
      @(posedge clk);
      #3;
    end
    line_valid[idx] = 1'b1;
    line_tag[idx] = tag;
    // idle cycles so the outputs are seen holding
    repeat (3) @(posedge clk);
    #1;
  endtask

  // refill and an APB read competing for the memory port
  task automatic fetch_with_read(input int unsigned addr, input int delay);
    int unsigned pick;
    pick = prog_addrs[$urandom % prog_addrs.size()];
    fork
      fetch(addr);
      begin
        repeat (delay) begin
          @(posedge clk);
          #1;
        end
        apb_access(1'b0, pick * 4, '0, 1'b0);
      end
    join
  endtask

  initial begin
    void'($urandom(32'h2163_473a));
    clk = 1'b0;
    reset = 1'b1;
    pc = '0;
    pc_wen = 1'b0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    {exp_pc, exp_instr, exp_jump, exp_ctrl, exp_hit, exp_rdata, exp_err} = '0;
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;

    foreach (block_base[b]) begin
      for (int i = 0; i < 8; i++) begin
        add_word(block_base[b] + i);
      end
    end
    foreach (prog_addrs[i]) apb_access(1'b1, prog_addrs[i] * 4, mem_model[prog_addrs[i]], 1'b0);
    foreach (prog_addrs[i]) apb_access(1'b0, prog_addrs[i] * 4, '0, 1'b0);

    // unaligned and out-of-range accesses leave words 5 and 0 unchanged
    apb_access(1'b1, 32'h0000_0016, 32'hdead_beef, 1'b1);
    apb_access(1'b1, mem_words * 4, 32'hdead_beef, 1'b1);
    apb_access(1'b0, 32'h0000_0013, '0, 1'b1);
    apb_access(1'b0, 32'h8000_0000, '0, 1'b1);
    apb_access(1'b0, 32'h0000_0014, '0, 1'b0);
    apb_access(1'b0, 32'h0000_0000, '0, 1'b0);

    foreach (prog_addrs[i]) fetch(prog_addrs[i]);
    // last block is still cached
    for (int i = 0; i < 8; i++) begin
      fetch(32'h3ff8 + i);
    end
    // same index with different tags
    repeat (2) begin
      fetch(32'h002);
      fetch(32'h402);
    end
    fetch(32'h402);
    for (int i = 0; i < 8; i++) begin
      fetch_with_read(32'h7fc + i, i % 3);
      fetch_with_read(32'hbfc + i, (i + 1) % 3);
    end

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire
